// File: axi_mem_slave.f
hdl/axi_mem_pkg.sv
hdl/mem_wr_port_if.sv
hdl/mem_rd_port_if.sv
hdl/axi_write_engine.sv
hdl/axi_read_engine.sv
hdl/mem_port_arbiter.sv
hdl/axi_mem_slave.sv
bench/tb_clock_gen.sv
bench/tb_axi_mem_slave.sv

// File: bench/tb_axi_mem_slave.sv
`timescale 1ns/100ps

module tb_axi_mem_slave;

	// 80 beats over all tests and up to 40 cycles per beat
	localparam int TOTAL_BEATS  = 80;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYCLES   = 40 * TOTAL_BEATS + RESET_CYCLES;

	localparam logic [1:0] OKAY   = 2'b00;
	localparam logic [1:0] SLVERR = 2'b10;

	logic        aclk;
	logic        aresetn;
	logic [3:0]  awid;
	logic [31:0] awaddr;
	logic [7:0]  awlen;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wlast;
	logic        wvalid;
	logic        wready;
	logic [3:0]  bid;
	logic [1:0]  bresp;
	logic        bvalid;
	logic        bready;
	logic [3:0]  arid;
	logic [31:0] araddr;
	logic [7:0]  arlen;
	logic        arvalid;
	logic        arready;
	logic [3:0]  rid;
	logic [31:0] rdata;
	logic [1:0]  rresp;
	logic        rlast;
	logic        rvalid;
	logic        rready;

	// byte image of the 4 KB memory
	logic [7:0]  ref_mem [4096];
	int          error_count;
	int          tests_run;
	int          tests_failed;
	int          cycles;
	int          seed;

	tb_clock_gen u_clock (
		.aclk    (aclk),
		.aresetn (aresetn)
	);

	axi_mem_slave uut (.*);

	// ------------------------------
	// helpers
	// ------------------------------
	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("Fail %s: expected %h, got %h", name, expected, actual);
		error_count++;
	endtask

	task automatic end_test(input string name, input int errors_before);
		tests_run++;
		if (error_count == errors_before) begin
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: %0d mismatches", name, error_count - errors_before);
		end
	endtask

	function automatic logic [31:0] model_word(input logic [31:0] addr);
		logic [11:0] base;
		base = {addr[11:2], 2'b00};
		return {ref_mem[base + 3], ref_mem[base + 2], ref_mem[base + 1], ref_mem[base]};
	endfunction

	task automatic write_burst(input logic [3:0] id, input logic [31:0] addr, input int beats,
			input int wlast_beat, input bit random_strb, input bit stall,
			input logic [1:0] exp_resp);
		logic [31:0] beat_addr;
		logic [31:0] data;
		logic [3:0]  strb;
		bit          done;

		@(negedge aclk);
		awid    = id;
		awaddr  = addr;
		awlen   = 8'(beats - 1);
		awvalid = 1'b1;
		@(posedge aclk);
		while (!awready) @(posedge aclk);
		@(negedge aclk);
		awvalid = 1'b0;
		// bid must come from the stored id
		awid    = ~id;

		for (int i = 0; i < beats; i++) begin
			beat_addr = {addr[31:2], 2'b00} + 32'(4 * i);
			data      = $urandom;
			strb      = random_strb ? 4'($urandom) : 4'hf;
			wdata     = data;
			wstrb     = strb;
			wlast     = (i == wlast_beat);
			wvalid    = 1'b1;
			@(posedge aclk);
			while (!wready) @(posedge aclk);
			// beats past 4 KB never reach memory
			if (beat_addr[31:12] == '0) begin
				for (int b = 0; b < 4; b++) begin
					if (strb[b]) begin
						ref_mem[beat_addr[11:0] + b] = data[8*b +: 8];
					end
				end
			end
			@(negedge aclk);
		end
		wvalid = 1'b0;
		wlast  = 1'b0;

		done = 1'b0;
		while (!done) begin
			bready = stall ? 1'($urandom) : 1'b1;
			@(posedge aclk);
			if (bvalid && bready) begin
				if (bid !== id) report_mismatch("bid", id, bid);
				if (bresp !== exp_resp) report_mismatch("bresp", exp_resp, bresp);
				done = 1'b1;
			end
			@(negedge aclk);
		end
		bready = 1'b0;
	endtask

	task automatic read_burst(input logic [3:0] id, input logic [31:0] addr, input int beats,
			input bit stall);
		logic [31:0] beat_addr;
		logic [31:0] exp_data;
		logic [1:0]  exp_resp;
		logic        exp_last;
		int          i;

		@(negedge aclk);
		arid    = id;
		araddr  = addr;
		arlen   = 8'(beats - 1);
		arvalid = 1'b1;
		@(posedge aclk);
		while (!arready) @(posedge aclk);
		@(negedge aclk);
		arvalid = 1'b0;
		// rid must come from the stored id
		arid    = ~id;

		i = 0;
		while (i < beats) begin
			rready = stall ? 1'($urandom) : 1'b1;
			@(posedge aclk);
			if (rvalid && rready) begin
				beat_addr = {addr[31:2], 2'b00} + 32'(4 * i);
				// out of range reads come back as zero with an error
				exp_data  = (beat_addr[31:12] == '0) ? model_word(beat_addr) : '0;
				exp_resp  = (beat_addr[31:12] == '0) ? OKAY : SLVERR;
				exp_last  = (i == beats - 1);
				if (rdata !== exp_data) report_mismatch("rdata", exp_data, rdata);
				if (rresp !== exp_resp) report_mismatch("rresp", exp_resp, rresp);
				if (rlast !== exp_last) report_mismatch("rlast", exp_last, rlast);
				if (rid !== id) report_mismatch("rid", id, rid);
				i++;
			end
			@(negedge aclk);
		end
		rready = 1'b0;
	endtask

	// ------------------------------
	// tests
	// ------------------------------
	task automatic single_write_read();
		int errors_before;
		errors_before = error_count;
		write_burst(4'h3, 32'h0000_0040, 1, 0, 1'b0, 1'b0, OKAY);
		read_burst(4'h5, 32'h0000_0040, 1, 1'b0);
		end_test("single write and read back", errors_before);
	endtask

	task automatic strobed_burst();
		int errors_before;
		errors_before = error_count;
		write_burst(4'h1, 32'h0000_0100, 8, 7, 1'b0, 1'b0, OKAY);
		write_burst(4'h2, 32'h0000_0100, 8, 7, 1'b1, 1'b0, OKAY);
		read_burst(4'h3, 32'h0000_0100, 8, 1'b0);
		end_test("burst with strobes", errors_before);
	endtask

	task automatic overlapping_bursts();
		int errors_before;
		errors_before = error_count;
		write_burst(4'h2, 32'h0000_0200, 8, 7, 1'b0, 1'b0, OKAY);
		fork
			write_burst(4'h4, 32'h0000_0300, 8, 7, 1'b0, 1'b1, OKAY);
			read_burst(4'h6, 32'h0000_0200, 8, 1'b1);
		join
		read_burst(4'h7, 32'h0000_0300, 8, 1'b0);
		end_test("overlapping write and read bursts", errors_before);
	endtask

	task automatic out_of_range_access();
		int errors_before;
		errors_before = error_count;
		write_burst(4'h1, 32'h0000_0010, 1, 0, 1'b0, 1'b0, OKAY);
		// 0x1010 shares its index bits with word 4
		write_burst(4'h8, 32'h0000_1010, 2, 1, 1'b0, 1'b0, SLVERR);
		read_burst(4'h9, 32'h0000_0010, 1, 1'b0);
		read_burst(4'ha, 32'h0000_1010, 2, 1'b0);
		end_test("out of range access", errors_before);
	endtask

	task automatic wlast_mismatch();
		int errors_before;
		errors_before = error_count;
		write_burst(4'hb, 32'h0000_0400, 4, 1, 1'b0, 1'b0, SLVERR);
		read_burst(4'hc, 32'h0000_0400, 4, 1'b0);
		end_test("wlast mismatch", errors_before);
	endtask

	task automatic unaligned_stepping();
		int errors_before;
		errors_before = error_count;
		write_burst(4'hd, 32'h0000_0503, 4, 3, 1'b0, 1'b0, OKAY);
		read_burst(4'he, 32'h0000_0503, 4, 1'b0);
		end_test("address stepping from unaligned start", errors_before);
	endtask

	// ------------------------------
	// run
	// ------------------------------
	initial begin
		seed = 92305;
		void'($urandom(seed));
		awid         = '0;
		awaddr       = '0;
		awlen        = '0;
		awvalid      = 1'b0;
		wdata        = '0;
		wstrb        = '0;
		wlast        = 1'b0;
		wvalid       = 1'b0;
		bready       = 1'b0;
		arid         = '0;
		araddr       = '0;
		arlen        = '0;
		arvalid      = 1'b0;
		rready       = 1'b0;
		error_count  = 0;
		tests_run    = 0;
		tests_failed = 0;

		@(posedge aresetn);
		single_write_read();
		strobed_burst();
		overlapping_bursts();
		out_of_range_access();
		wlast_mismatch();
		unaligned_stepping();

		$display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed,
			error_count);
		if (tests_failed == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge aclk);
			cycles++;
		end
		$display("timeout after %0d cycles, a handshake never completed", cycles);
		$display("Something failed");
		$finish;
	end

endmodule

// File: bench/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
	output logic aclk,
	output logic aresetn
);

	// 10 ns period
	initial begin
		aclk = 1'b0;
		forever #5 aclk = ~aclk;
	end

	initial begin
		aresetn = 1'b0;
		repeat (16) @(posedge aclk);
		@(negedge aclk);
		aresetn = 1'b1;
	end

endmodule

// File: hdl/axi_mem_slave.sv
`timescale 1ns/100ps

module axi_mem_slave (
	input  logic                                    aclk,
	input  logic                                    aresetn,

	// write address
	input  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    awid,
	input  logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0]  awaddr,
	input  logic [axi_mem_pkg::AXI_LEN_WIDTH-1:0]   awlen,
	input  logic                                    awvalid,
	output logic                                    awready,

	// write data
	input  logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0]  wdata,
	input  logic [axi_mem_pkg::AXI_STRB_WIDTH-1:0]  wstrb,
	input  logic                                    wlast,
	input  logic                                    wvalid,
	output logic                                    wready,

	// write response
	output logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    bid,
	output logic [1:0]                              bresp,
	output logic                                    bvalid,
	input  logic                                    bready,

	// read address
	input  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    arid,
	input  logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0]  araddr,
	input  logic [axi_mem_pkg::AXI_LEN_WIDTH-1:0]   arlen,
	input  logic                                    arvalid,
	output logic                                    arready,

	// read data
	output logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    rid,
	output logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0]  rdata,
	output logic [1:0]                              rresp,
	output logic                                    rlast,
	output logic                                    rvalid,
	input  logic                                    rready
);

	mem_wr_port_if wr_port ();
	mem_rd_port_if rd_port ();

	axi_write_engine u_write (
		.aclk    (aclk),
		.aresetn (aresetn),
		.awid    (awid),
		.awaddr  (awaddr),
		.awlen   (awlen),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wlast   (wlast),
		.wvalid  (wvalid),
		.wready  (wready),
		.bid     (bid),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.mem     (wr_port.engine)
	);

	axi_read_engine u_read (
		.aclk    (aclk),
		.aresetn (aresetn),
		.arid    (arid),
		.araddr  (araddr),
		.arlen   (arlen),
		.arvalid (arvalid),
		.arready (arready),
		.rid     (rid),
		.rdata   (rdata),
		.rresp   (rresp),
		.rlast   (rlast),
		.rvalid  (rvalid),
		.rready  (rready),
		.mem     (rd_port.engine)
	);

	// owns the storage and serves one access per cycle
	mem_port_arbiter u_arbiter (
		.aclk    (aclk),
		.aresetn (aresetn),
		.wr      (wr_port.memory),
		.rd      (rd_port.memory)
	);

endmodule

// File: hdl/mem_port_arbiter.sv
`timescale 1ns/100ps

module mem_port_arbiter (
	input  logic             aclk,
	input  logic             aresetn,

	mem_wr_port_if.memory    wr,
	mem_rd_port_if.memory    rd
);

	logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0]   storage [axi_mem_pkg::MEM_WORDS];
	logic                                     last_wr;
	logic                                     grant_wr;
	logic                                     grant_rd;
	logic [axi_mem_pkg::MEM_INDEX_WIDTH-1:0]  mem_index;
	logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0]   rdata_q;
	logic                                     rvalid_q;

	// ------------------------------
	// grant
	// ------------------------------

	// on a tie the loser of the previous tie goes first
	assign grant_wr = wr.valid && (!rd.valid || !last_wr);
	assign grant_rd = rd.valid && !grant_wr;

	assign wr.ready = grant_wr;
	assign rd.ready = grant_rd;

	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			last_wr  <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (wr.valid && rd.valid) begin
				last_wr <= grant_wr;
			end
			rvalid_q <= grant_rd;
		end
	end

	// ------------------------------
	// single port storage
	// ------------------------------
	assign mem_index = grant_wr ? wr.index : rd.index;

	always_ff @(posedge aclk) begin
		if (grant_wr) begin
			for (int b = 0; b < axi_mem_pkg::AXI_STRB_WIDTH; b++) begin
				if (wr.strb[b]) begin
					storage[mem_index][8*b +: 8] <= wr.data[8*b +: 8];
				end
			end
		end
		// registered read path
		if (grant_rd) begin
			rdata_q <= storage[mem_index];
		end
	end

	assign rd.rdata  = rdata_q;
	assign rd.rvalid = rvalid_q;

endmodule

// File: hdl/axi_read_engine.sv
`timescale 1ns/100ps

module axi_read_engine (
	input  logic                                    aclk,
	input  logic                                    aresetn,

	input  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    arid,
	input  logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0]  araddr,
	input  logic [axi_mem_pkg::AXI_LEN_WIDTH-1:0]   arlen,
	input  logic                                    arvalid,
	output logic                                    arready,

	output logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    rid,
	output logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0]  rdata,
	output logic [1:0]                              rresp,
	output logic                                    rlast,
	output logic                                    rvalid,
	input  logic                                    rready,

	mem_rd_port_if.engine                           mem
);

	logic                                    busy;
	logic                                    issuing;
	logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    id_q;
	axi_mem_pkg::axi_addr_u                  addr_q;
	logic [axi_mem_pkg::AXI_LEN_WIDTH-1:0]   count;
	logic                                    pend_last;
	logic                                    rvalid_q;
	logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0]  rdata_q;
	logic [1:0]                              rresp_q;
	logic                                    rlast_q;
	logic                                    out_of_range;
	logic                                    last_issue;
	logic                                    ar_fire;
	logic                                    r_fire;
	logic                                    issue_slot;
	logic                                    issue_fire;

	assign out_of_range = (addr_q.word.upper != '0);
	assign last_issue   = (count == '0);

	assign arready = !busy;
	assign ar_fire = arvalid && arready;
	assign r_fire  = rvalid_q && rready;

	// mem.rvalid high means the single request is still in flight.
	// the next one waits for room in the R register
	assign issue_slot = issuing && !mem.rvalid && (!rvalid_q || rready);
	assign issue_fire = issue_slot && (out_of_range || mem.ready);

	assign mem.valid = issue_slot && !out_of_range;
	assign mem.index = addr_q.word.index;

	assign rid    = id_q;
	assign rdata  = rdata_q;
	assign rresp  = rresp_q;
	assign rlast  = rlast_q;
	assign rvalid = rvalid_q;

	// ------------------------------
	// burst control
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy     <= 1'b0;
			issuing  <= 1'b0;
			rvalid_q <= 1'b0;
		end else begin
			if (ar_fire) begin
				busy    <= 1'b1;
				issuing <= 1'b1;
			end
			if (r_fire && rlast_q) begin
				busy <= 1'b0;
			end
			if (issue_fire && last_issue) begin
				issuing <= 1'b0;
			end
			if (r_fire) begin
				rvalid_q <= 1'b0;
			end
			if (mem.rvalid || (issue_fire && out_of_range)) begin
				rvalid_q <= 1'b1;
			end
		end
	end

	// address walk
	always_ff @(posedge aclk) begin
		if (ar_fire) begin
			id_q       <= arid;
			addr_q.raw <= araddr;
			count      <= arlen;
		end else if (issue_fire) begin
			count      <= count - 1'b1;
			addr_q.raw <= addr_q.raw
				+ (axi_mem_pkg::AXI_ADDR_WIDTH)'(axi_mem_pkg::AXI_STRB_WIDTH);
			pend_last  <= last_issue;
		end
	end

	// R output register
	always_ff @(posedge aclk) begin
		if (mem.rvalid) begin
			rdata_q <= mem.rdata;
			rresp_q <= axi_mem_pkg::RESP_OKAY;
			rlast_q <= pend_last;
		end else if (issue_fire && out_of_range) begin
			rdata_q <= '0;
			rresp_q <= axi_mem_pkg::RESP_SLVERR;
			rlast_q <= last_issue;
		end
	end

endmodule

// File: hdl/axi_write_engine.sv
`timescale 1ns/100ps

module axi_write_engine (
	input  logic                                    aclk,
	input  logic                                    aresetn,

	input  logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    awid,
	input  logic [axi_mem_pkg::AXI_ADDR_WIDTH-1:0]  awaddr,
	input  logic [axi_mem_pkg::AXI_LEN_WIDTH-1:0]   awlen,
	input  logic                                    awvalid,
	output logic                                    awready,

	input  logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0]  wdata,
	input  logic [axi_mem_pkg::AXI_STRB_WIDTH-1:0]  wstrb,
	input  logic                                    wlast,
	input  logic                                    wvalid,
	output logic                                    wready,

	output logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    bid,
	output logic [1:0]                              bresp,
	output logic                                    bvalid,
	input  logic                                    bready,

	mem_wr_port_if.engine                           mem
);

	logic                                    busy;
	logic                                    bvalid_q;
	logic                                    err;
	logic [axi_mem_pkg::AXI_ID_WIDTH-1:0]    id_q;
	axi_mem_pkg::axi_addr_u                  addr_q;
	logic [axi_mem_pkg::AXI_LEN_WIDTH-1:0]   count;
	logic                                    out_of_range;
	logic                                    last_beat;
	logic                                    aw_fire;
	logic                                    w_fire;

	assign out_of_range = (addr_q.word.upper != '0);
	assign last_beat    = (count == '0);

	// no new burst while a response is still waiting
	assign awready = !busy && !bvalid_q;
	assign aw_fire = awvalid && awready;

	// out of range beats are dropped without a memory slot
	assign wready = busy && (out_of_range || mem.ready);
	assign w_fire = wvalid && wready;

	assign mem.valid = busy && wvalid && !out_of_range;
	assign mem.index = addr_q.word.index;
	assign mem.data  = wdata;
	assign mem.strb  = wstrb;

	assign bid    = id_q;
	assign bresp  = err ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
	assign bvalid = bvalid_q;

	// ------------------------------
	// burst control
	// ------------------------------
	always_ff @(posedge aclk) begin
		if (!aresetn) begin
			busy     <= 1'b0;
			bvalid_q <= 1'b0;
			err      <= 1'b0;
		end else begin
			if (bvalid_q && bready) begin
				bvalid_q <= 1'b0;
			end
			if (aw_fire) begin
				busy <= 1'b1;
				err  <= 1'b0;
			end else if (w_fire) begin
				if (last_beat) begin
					busy     <= 1'b0;
					bvalid_q <= 1'b1;
				end
				// sticky until the next burst
				if (out_of_range || (wlast != last_beat)) begin
					err <= 1'b1;
				end
			end
		end
	end

	// address and beat count
	always_ff @(posedge aclk) begin
		if (aw_fire) begin
			id_q       <= awid;
			addr_q.raw <= awaddr;
			count      <= awlen;
		end else if (w_fire) begin
			count      <= count - 1'b1;
			addr_q.raw <= addr_q.raw
				+ (axi_mem_pkg::AXI_ADDR_WIDTH)'(axi_mem_pkg::AXI_STRB_WIDTH);
		end
	end

endmodule

// File: hdl/mem_rd_port_if.sv
`timescale 1ns/100ps

interface mem_rd_port_if;

	logic                                      valid;
	logic                                      ready;
	logic [axi_mem_pkg::MEM_INDEX_WIDTH-1:0]   index;
	logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0]    rdata;
	logic                                      rvalid;

	// rvalid pulses one cycle after an accepted request
	modport engine (
		output valid, index,
		input  ready, rdata, rvalid
	);

	modport memory (
		input  valid, index,
		output ready, rdata, rvalid
	);

endinterface

// File: hdl/mem_wr_port_if.sv
`timescale 1ns/100ps

interface mem_wr_port_if;

	logic                                      valid;
	logic                                      ready;
	logic [axi_mem_pkg::MEM_INDEX_WIDTH-1:0]   index;
	logic [axi_mem_pkg::AXI_DATA_WIDTH-1:0]    data;
	logic [axi_mem_pkg::AXI_STRB_WIDTH-1:0]    strb;

	// write happens on the edge where valid and ready are both high
	modport engine (
		output valid, index, data, strb,
		input  ready
	);

	modport memory (
		input  valid, index, data, strb,
		output ready
	);

endinterface

// File: hdl/axi_mem_pkg.sv
package axi_mem_pkg;

	// AXI channel widths
	localparam int AXI_ID_WIDTH   = 4;
	localparam int AXI_ADDR_WIDTH = 32;
	localparam int AXI_LEN_WIDTH  = 8;
	localparam int AXI_DATA_SIZE  = 2;
	localparam int AXI_DATA_WIDTH = 32;
	localparam int AXI_STRB_WIDTH = 4;

	// 4 KB word memory
	localparam int MEM_INDEX_WIDTH = 10;
	localparam int MEM_WORDS       = 1024;

	localparam logic [1:0] RESP_OKAY   = 2'b00;
	localparam logic [1:0] RESP_SLVERR = 2'b10;

	// read as a byte address or as upper bits, word index and byte offset
	// nonzero upper means the access lies beyond the memory
	typedef union packed {
		logic [AXI_ADDR_WIDTH-1:0] raw;
		struct packed {
			logic [AXI_ADDR_WIDTH-MEM_INDEX_WIDTH-AXI_DATA_SIZE-1:0] upper;
			logic [MEM_INDEX_WIDTH-1:0]                             index;
			logic [AXI_DATA_SIZE-1:0]                               offset;
		} word;
	} axi_addr_u;

endpackage
